// ==== hdl/rp_adc_frontend.sv ====
// ADC input stage, one register per channel
// ADC words are expected on adc_clk, no IO timing stage in front of it
// Loopback samples are taken as is, they must already be saturated

`timescale 1ns/1ps
`default_nettype none

`include "rp_config.svh"

module rp_adc_frontend (
  input  wire                          adc_clk,
  input  wire                          rst_n_i,
  input  wire rp_sample_pkg::adc_raw_t adc_a_dat_i,    // Raw ADC A
  input  wire rp_sample_pkg::adc_raw_t adc_b_dat_i,    // Raw ADC B
  input  wire                          digital_loop_i, // Select DAC samples
  input  wire rp_sample_pkg::smp_t     loop_a_i,
  input  wire rp_sample_pkg::smp_t     loop_b_i,
  output rp_sample_pkg::smp_t          adc_a_o,
  output rp_sample_pkg::smp_t          adc_b_o
);

  import rp_sample_pkg::*;

  // Drop reserved LSBs, negative slope to two's complement
  function automatic smp_t adc_conv(input adc_raw_t raw);
    logic [`SMP_DW-1:0] code;
    code = raw[`ADC_RAW_DW-1 -: `SMP_DW];
    return {code[`SMP_DW-1], ~code[`SMP_DW-2:0]};  // MSB kept
  endfunction

  //////////////////////////////////////////////////
  // Sample registers
  //////////////////////////////////////////////////

  always_ff @(posedge adc_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      adc_a_o <= '0;
      adc_b_o <= '0;
    end else begin
      adc_a_o <= digital_loop_i ? loop_a_i : adc_conv(adc_a_dat_i);
      adc_b_o <= digital_loop_i ? loop_b_i : adc_conv(adc_b_dat_i);
    end
  end

endmodule

`default_nettype wire

// ==== hdl/rp_config.svh ====
// Widths and address map of the analog front end
// All values are fixed at build time, nothing here is run-time configurable
// Register offsets are full SYS_AW wide byte addresses

`ifndef RP_CONFIG_SVH
`define RP_CONFIG_SVH

`define ADC_RAW_DW  16            // Raw ADC word, 2 LSBs reserved
`define SMP_DW      14            // Sample width on both paths
`define SYS_AW      16            // System bus address
`define SYS_DW      32            // System bus data
`define EXP_DW      8             // Expansion connector pins
`define PDM_N       4             // PDM channels
`define PDM_DW      8             // PDM level width
`define PDM_RNG     255           // Fixed PDM range

`define REG_ID      16'h0000      // Read only
`define REG_CTRL    16'h0004
`define REG_EXP_DIR 16'h0008
`define REG_EXP_OUT 16'h000C
`define REG_EXP_IN  16'h0010      // Read only
`define REG_PDM     16'h0020
`define BOARD_ID    32'h5250_0A01

`endif

// ==== hdl/rp_dac_backend.sv ====
// DAC output stage, generator plus controller per channel
// Sums saturate at the 14-bit limits, no wrap around
// smp_*_o is combinational and feeds the ADC loopback
// dac_*_o is one cycle behind the gen/ctl inputs

`timescale 1ns/1ps
`default_nettype none

`include "rp_config.svh"

module rp_dac_backend (
  input  wire                       adc_clk,
  input  wire                       rst_n_i,
  input  wire rp_sample_pkg::smp_t  gen_a_i,   // Generator A
  input  wire rp_sample_pkg::smp_t  gen_b_i,   // Generator B
  input  wire rp_sample_pkg::smp_t  ctl_a_i,   // Controller A
  input  wire rp_sample_pkg::smp_t  ctl_b_i,   // Controller B
  output rp_sample_pkg::smp_t       smp_a_o,   // Saturated sum A
  output rp_sample_pkg::smp_t       smp_b_o,   // Saturated sum B
  output rp_sample_pkg::dac_code_t  dac_a_o,
  output rp_sample_pkg::dac_code_t  dac_b_o
);

  import rp_sample_pkg::*;

  // Pin code of a zero sample
  localparam dac_code_t DAC_ZERO = {1'b0, {(`SMP_DW-1){1'b1}}};

  // Add at SMP_DW+1 bits, clip on overflow
  function automatic smp_t sat_add(input smp_t a, input smp_t b);
    logic signed [`SMP_DW:0] sum;
    sum = a + b;                                    // Sign extended
    if (sum[`SMP_DW] != sum[`SMP_DW-1])
      return {sum[`SMP_DW], {(`SMP_DW-1){~sum[`SMP_DW]}}};
    return sum[`SMP_DW-1:0];
  endfunction

  // Two's complement to negative slope offset code
  function automatic dac_code_t dac_code(input smp_t s);
    return {s[`SMP_DW-1], ~s[`SMP_DW-2:0]};
  endfunction

  assign smp_a_o = sat_add(gen_a_i, ctl_a_i);
  assign smp_b_o = sat_add(gen_b_i, ctl_b_i);

  //////////////////////////////////////////////////
  // Output registers
  //////////////////////////////////////////////////

  always_ff @(posedge adc_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      dac_a_o <= DAC_ZERO;             // Mid scale
      dac_b_o <= DAC_ZERO;
    end else begin
      dac_a_o <= dac_code(smp_a_o);
      dac_b_o <= dac_code(smp_b_o);
    end
  end

endmodule

`default_nettype wire

// ==== hdl/rp_frontend_top.sv ====
// Analog front end top, single adc_clk domain
// Converter pins are plain registered ports, no IO primitives
// Generator and controller streams come from outside, one sample per cycle

`timescale 1ns/1ps
`default_nettype none

`include "rp_config.svh"

module rp_frontend_top (
  input  wire                          adc_clk,
  input  wire                          rst_n_i,
  // ADC
  input  wire rp_sample_pkg::adc_raw_t adc_a_dat_i,
  input  wire rp_sample_pkg::adc_raw_t adc_b_dat_i,
  output rp_sample_pkg::smp_t          adc_a_o,
  output rp_sample_pkg::smp_t          adc_b_o,
  // Generator and controller streams
  input  wire rp_sample_pkg::smp_t     gen_a_i,
  input  wire rp_sample_pkg::smp_t     gen_b_i,
  input  wire rp_sample_pkg::smp_t     ctl_a_i,
  input  wire rp_sample_pkg::smp_t     ctl_b_i,
  // DAC
  output rp_sample_pkg::dac_code_t     dac_a_o,
  output rp_sample_pkg::dac_code_t     dac_b_o,
  // System bus
  input  wire rp_regs_pkg::sys_addr_t  sys_addr_i,
  input  wire rp_regs_pkg::sys_data_t  sys_wdata_i,
  input  wire                          sys_wen_i,
  input  wire                          sys_ren_i,
  output rp_regs_pkg::sys_data_t       sys_rdata_o,
  output wire                          sys_ack_o,
  output wire                          sys_err_o,
  // Board IO
  output wire [7:0]                    led_o,
  input  wire [`EXP_DW-1:0]            exp_dat_i,
  output wire [`EXP_DW-1:0]            exp_dat_o,
  output wire [`EXP_DW-1:0]            exp_dir_o,
  output wire [`PDM_N-1:0]             pdm_o
);

  import rp_sample_pkg::*;
  import rp_regs_pkg::*;

  logic        digital_loop;           // HK to ADC mux
  pdm_levels_t pdm_cfg;
  smp_t        dac_smp_a;              // Saturated sums, loopback source
  smp_t        dac_smp_b;

  //////////////////////////////////////////////////
  // Sample paths
  //////////////////////////////////////////////////

  rp_adc_frontend u_adc (
    .adc_clk        (adc_clk),
    .rst_n_i        (rst_n_i),
    .adc_a_dat_i    (adc_a_dat_i),
    .adc_b_dat_i    (adc_b_dat_i),
    .digital_loop_i (digital_loop),
    .loop_a_i       (dac_smp_a),
    .loop_b_i       (dac_smp_b),
    .adc_a_o        (adc_a_o),
    .adc_b_o        (adc_b_o)
  );

  rp_dac_backend u_dac (
    .adc_clk (adc_clk),
    .rst_n_i (rst_n_i),
    .gen_a_i (gen_a_i),
    .gen_b_i (gen_b_i),
    .ctl_a_i (ctl_a_i),
    .ctl_b_i (ctl_b_i),
    .smp_a_o (dac_smp_a),
    .smp_b_o (dac_smp_b),
    .dac_a_o (dac_a_o),
    .dac_b_o (dac_b_o)
  );

  //////////////////////////////////////////////////
  // Housekeeping and PDM
  //////////////////////////////////////////////////

  rp_hk_regs u_hk (
    .adc_clk        (adc_clk),
    .rst_n_i        (rst_n_i),
    .sys_addr_i     (sys_addr_i),
    .sys_wdata_i    (sys_wdata_i),
    .sys_wen_i      (sys_wen_i),
    .sys_ren_i      (sys_ren_i),
    .sys_rdata_o    (sys_rdata_o),
    .sys_ack_o      (sys_ack_o),
    .sys_err_o      (sys_err_o),
    .digital_loop_o (digital_loop),
    .led_o          (led_o),
    .exp_dir_o      (exp_dir_o),
    .exp_dat_o      (exp_dat_o),
    .exp_dat_i      (exp_dat_i),
    .pdm_cfg_o      (pdm_cfg)
  );

  rp_pdm u_pdm (
    .adc_clk (adc_clk),
    .rst_n_i (rst_n_i),
    .cfg_i   (pdm_cfg),
    .pdm_o   (pdm_o)
  );

endmodule

`default_nettype wire

// ==== hdl/rp_hk_regs.sv ====
// Housekeeping registers on the system bus
// Every wen/ren strobe is acked exactly one cycle later
// Unmapped addresses ack with err and zero read data
// Writes to ID and EXP_IN are dropped silently
// exp_dat_i is asynchronous, two flops before it is readable

`timescale 1ns/1ps
`default_nettype none

`include "rp_config.svh"

module rp_hk_regs (
  input  wire                          adc_clk,
  input  wire                          rst_n_i,
  // System bus
  input  wire rp_regs_pkg::sys_addr_t  sys_addr_i,
  input  wire rp_regs_pkg::sys_data_t  sys_wdata_i,
  input  wire                          sys_wen_i,      // Single cycle
  input  wire                          sys_ren_i,      // Single cycle
  output rp_regs_pkg::sys_data_t       sys_rdata_o,
  output logic                         sys_ack_o,
  output logic                         sys_err_o,
  // Configuration out
  output logic                         digital_loop_o,
  output logic [7:0]                   led_o,
  output logic [`EXP_DW-1:0]           exp_dir_o,      // 1 drives the pin
  output logic [`EXP_DW-1:0]           exp_dat_o,
  input  wire  [`EXP_DW-1:0]           exp_dat_i,
  output rp_regs_pkg::pdm_levels_t     pdm_cfg_o
);

  import rp_regs_pkg::*;

  reg_word_u          wr_word;       // Write data, two views
  ctrl_fields_t       rd_ctrl;       // CTRL readback
  sys_data_t          rdata_nxt;
  logic               addr_hit;
  logic [`EXP_DW-1:0] exp_meta_q;    // First sync stage
  logic [`EXP_DW-1:0] exp_sync_q;

  assign wr_word = reg_word_u'(sys_wdata_i);

  //////////////////////////////////////////////////
  // Address decode and read mux
  //////////////////////////////////////////////////

  always_comb begin
    rd_ctrl              = '0;
    rd_ctrl.led          = led_o;
    rd_ctrl.digital_loop = digital_loop_o;
  end

  always_comb begin
    addr_hit  = 1'b1;
    rdata_nxt = '0;
    case (sys_addr_i)
      `REG_ID:      rdata_nxt = `BOARD_ID;
      `REG_CTRL:    rdata_nxt = rd_ctrl;
      `REG_EXP_DIR: rdata_nxt = {{(`SYS_DW-`EXP_DW){1'b0}}, exp_dir_o};
      `REG_EXP_OUT: rdata_nxt = {{(`SYS_DW-`EXP_DW){1'b0}}, exp_dat_o};
      `REG_EXP_IN:  rdata_nxt = {{(`SYS_DW-`EXP_DW){1'b0}}, exp_sync_q};
      `REG_PDM:     rdata_nxt = pdm_cfg_o;
      default:      addr_hit  = 1'b0;   // Hole in the map
    endcase
  end

  //////////////////////////////////////////////////
  // Registers and bus response
  //////////////////////////////////////////////////

  always_ff @(posedge adc_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      sys_ack_o      <= 1'b0;
      sys_err_o      <= 1'b0;
      digital_loop_o <= 1'b0;
      led_o          <= '0;
      exp_dir_o      <= '0;       // All pins input
      exp_dat_o      <= '0;
      pdm_cfg_o      <= '0;
      exp_meta_q     <= '0;
      exp_sync_q     <= '0;
    end else begin
      exp_meta_q <= exp_dat_i;
      exp_sync_q <= exp_meta_q;
      sys_ack_o  <= sys_wen_i | sys_ren_i;
      sys_err_o  <= (sys_wen_i | sys_ren_i) & ~addr_hit;
      if (sys_wen_i) begin
        case (sys_addr_i)
          `REG_CTRL: begin
            digital_loop_o <= wr_word.ctrl.digital_loop;
            led_o          <= wr_word.ctrl.led;
          end
          `REG_EXP_DIR: exp_dir_o <= sys_wdata_i[`EXP_DW-1:0];
          `REG_EXP_OUT: exp_dat_o <= sys_wdata_i[`EXP_DW-1:0];
          `REG_PDM:     pdm_cfg_o <= wr_word.pdm;
          default: ;                // Read only or unmapped
        endcase
      end
    end
  end

  // Read data, only looked at with a read ack
  always_ff @(posedge adc_clk) begin
    if (sys_ren_i)
      sys_rdata_o <= rdata_nxt;
  end

endmodule

`default_nettype wire

// ==== hdl/rp_pdm.sv ====
// First order PDM modulators, one per channel
// Range is fixed to PDM_RNG, a level of PDM_RNG gives a constant 1
// Density settles within PDM_RNG cycles of a level change

`timescale 1ns/1ps
`default_nettype none

`include "rp_config.svh"

module rp_pdm (
  input  wire                              adc_clk,
  input  wire                              rst_n_i,
  input  wire rp_regs_pkg::pdm_levels_t    cfg_i,   // Levels, ch 0 low byte
  output wire logic [`PDM_N-1:0]           pdm_o    // 1-bit outputs
);

  // One spare bit holds acc + level before the subtract
  localparam int unsigned ACC_W = `PDM_DW + 1;
  localparam logic [ACC_W-1:0] RNG = ACC_W'(`PDM_RNG);

  //////////////////////////////////////////////////
  // Modulators
  //////////////////////////////////////////////////

  for (genvar ch = 0; ch < `PDM_N; ch++) begin : g_ch
    logic [ACC_W-1:0] acc_q;      // Stays below RNG
    logic [ACC_W-1:0] sum;
    logic             bit_q;

    assign sum = acc_q + ACC_W'(cfg_i[ch]);

    always_ff @(posedge adc_clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
        acc_q <= '0;
        bit_q <= 1'b0;
      end else if (sum >= RNG) begin
        acc_q <= sum - RNG;       // Carry out, emit a one
        bit_q <= 1'b1;
      end else begin
        acc_q <= sum;
        bit_q <= 1'b0;
      end
    end

    assign pdm_o[ch] = bit_q;
  end

endmodule

`default_nettype wire

// ==== hdl/rp_regs_pkg.sv ====
// Register word types of the housekeeping block
// The write word is decoded two ways through reg_word_u, so both views
// must stay exactly SYS_DW bits wide

`default_nettype none

`include "rp_config.svh"

package rp_regs_pkg;

  //////////////////////////////////////////////////
  // Bus words
  //////////////////////////////////////////////////

  typedef logic [`SYS_AW-1:0] sys_addr_t;   // Byte address
  typedef logic [`SYS_DW-1:0] sys_data_t;   // Read and write data

  //////////////////////////////////////////////////
  // Register views
  //////////////////////////////////////////////////

  // Control word, loopback in bit 0, LEDs above it
  typedef struct packed {
    logic [`SYS_DW-10:0] rsv;               // Reads as zero
    logic [7:0]          led;               // LED pins
    logic                digital_loop;      // DAC to ADC loopback
  } ctrl_fields_t;

  // Four PDM levels, channel 0 in the low byte
  typedef logic [`PDM_N-1:0][`PDM_DW-1:0] pdm_levels_t;

  // Same write word, seen by CTRL or by PDM
  typedef union packed {
    ctrl_fields_t ctrl;
    pdm_levels_t  pdm;
  } reg_word_u;

endpackage

`default_nettype wire

// ==== hdl/rp_sample_pkg.sv ====
// Sample stream types shared by the ADC and DAC paths
// Samples are two's complement; converter codes are negative-slope offset
// binary as seen on the converter pins

`default_nettype none

`include "rp_config.svh"

package rp_sample_pkg;

  //////////////////////////////////////////////////
  // Stream types
  //////////////////////////////////////////////////

  // Two's complement sample, ADC and DAC side alike
  typedef logic signed [`SMP_DW-1:0] smp_t;

  // DAC pin code, 0x1FFF is mid scale
  typedef logic [`SMP_DW-1:0] dac_code_t;

  // Raw ADC word
  // Upper SMP_DW bits carry the code, the rest is reserved
  typedef logic [`ADC_RAW_DW-1:0] adc_raw_t;

endpackage

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# Verilator build and run of tb_rp_frontend, result taken from sim.log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f verilog.f \
  --top-module tb_rp_frontend -o tb_rp_frontend \
  && ./obj_dir/tb_rp_frontend > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "TESTS PASSED" sim.log && echo "Simulation passed" \
  || { echo "Simulation failed, see sim.log"; exit 1; }

// ==== tb/rp_frontend_assert.sv ====
// Bound checks on the converter paths and the system bus
// Data checks skip the first cycle after reset release
// ADC checks hold only while loopback was off in the previous cycle

`timescale 1ns/1ps
`default_nettype none

`include "rp_config.svh"

module rp_frontend_assert (
  input wire                   adc_clk,
  input wire                   rst_n_i,
  input wire [`ADC_RAW_DW-1:0] raw_a_i,     // ADC pins
  input wire [`ADC_RAW_DW-1:0] raw_b_i,
  input wire                   loop_i,      // Loopback select
  input wire [`SMP_DW-1:0]     gen_a_i,
  input wire [`SMP_DW-1:0]     gen_b_i,
  input wire [`SMP_DW-1:0]     ctl_a_i,
  input wire [`SMP_DW-1:0]     ctl_b_i,
  input wire [`SMP_DW-1:0]     adc_a_i,     // DUT ADC outputs
  input wire [`SMP_DW-1:0]     adc_b_i,
  input wire [`SMP_DW-1:0]     dac_a_i,     // DUT DAC codes
  input wire [`SMP_DW-1:0]     dac_b_i,
  input wire [`SYS_AW-1:0]     addr_i,
  input wire                   wen_i,
  input wire                   ren_i,
  input wire [`SYS_DW-1:0]     rdata_i,
  input wire                   ack_i,
  input wire                   err_i
);

  localparam int SMP_MAX = 2 ** (`SMP_DW - 1) - 1;
  localparam int SMP_MIN = -(2 ** (`SMP_DW - 1));
  localparam logic [`SMP_DW-1:0] LOW_MASK = {1'b0, {(`SMP_DW-1){1'b1}}};  // All but MSB

  int unsigned fail_cnt = 0;     // Read by the testbench

  // Reserved LSBs dropped, all but the MSB inverted
  function automatic logic [`SMP_DW-1:0] adc_rule(input logic [`ADC_RAW_DW-1:0] raw);
    return raw[`ADC_RAW_DW-1:`ADC_RAW_DW-`SMP_DW] ^ LOW_MASK;
  endfunction

  // True sum clipped to sample range, then pin code
  function automatic logic [`SMP_DW-1:0] dac_rule(input logic [`SMP_DW-1:0] g,
                                                  input logic [`SMP_DW-1:0] c);
    int s;
    s = int'($signed(g)) + int'($signed(c));
    if (s > SMP_MAX)
      s = SMP_MAX;
    else if (s < SMP_MIN)
      s = SMP_MIN;
    return s[`SMP_DW-1:0] ^ LOW_MASK;
  endfunction

  function automatic logic mapped(input logic [`SYS_AW-1:0] a);
    return a inside {`REG_ID, `REG_CTRL, `REG_EXP_DIR, `REG_EXP_OUT, `REG_EXP_IN, `REG_PDM};
  endfunction

  //////////////////////////////////////////////////
  // Converter paths
  //////////////////////////////////////////////////

  a_adc_conv: assert property (@(posedge adc_clk) disable iff (!rst_n_i)
      $past(rst_n_i) && !$past(loop_i) |->
        adc_a_i == adc_rule($past(raw_a_i)) && adc_b_i == adc_rule($past(raw_b_i)))
    else begin
      $error("ADC output differs from the converted raw word");
      fail_cnt++;
    end

  a_dac_code: assert property (@(posedge adc_clk) disable iff (!rst_n_i)
      $past(rst_n_i) |->
        dac_a_i == dac_rule($past(gen_a_i), $past(ctl_a_i)) &&
        dac_b_i == dac_rule($past(gen_b_i), $past(ctl_b_i)))
    else begin
      $error("DAC code differs from the saturated sum");
      fail_cnt++;
    end

  //////////////////////////////////////////////////
  // System bus
  //////////////////////////////////////////////////

  // Ack exactly one cycle after each strobe, err never alone
  a_ack_timing: assert property (@(posedge adc_clk) disable iff (!rst_n_i)
      $past(rst_n_i) |-> ack_i == $past(wen_i || ren_i) && (ack_i || !err_i))
    else begin
      $error("bus ack is not one cycle after the strobe");
      fail_cnt++;
    end

  a_unmapped: assert property (@(posedge adc_clk) disable iff (!rst_n_i)
      (wen_i || ren_i) && !mapped(addr_i) |=> err_i && (!$past(ren_i) || rdata_i == '0))
    else begin
      $error("unmapped access without error or with nonzero read data");
      fail_cnt++;
    end

  a_mapped: assert property (@(posedge adc_clk) disable iff (!rst_n_i)
      (wen_i || ren_i) && mapped(addr_i) |=> !err_i)
    else begin
      $error("mapped access returned an error");
      fail_cnt++;
    end

endmodule

bind rp_frontend_top rp_frontend_assert u_chk (
  .adc_clk (adc_clk),
  .rst_n_i (rst_n_i),
  .raw_a_i (adc_a_dat_i),
  .raw_b_i (adc_b_dat_i),
  .loop_i  (digital_loop),
  .gen_a_i (gen_a_i),
  .gen_b_i (gen_b_i),
  .ctl_a_i (ctl_a_i),
  .ctl_b_i (ctl_b_i),
  .adc_a_i (adc_a_o),
  .adc_b_i (adc_b_o),
  .dac_a_i (dac_a_o),
  .dac_b_i (dac_b_o),
  .addr_i  (sys_addr_i),
  .wen_i   (sys_wen_i),
  .ren_i   (sys_ren_i),
  .rdata_i (sys_rdata_o),
  .ack_i   (sys_ack_o),
  .err_i   (sys_err_o)
);

`default_nettype wire

// ==== tb/tb_rp_frontend.sv ====
// Testbench for the analog front end top
// Converter and bus timing checks come from the bound assertion module
// Register readback, loopback and PDM density are compared here
// Single 10 ns adc_clk, inputs change on the rising edge only

`timescale 1ns/1ps
`default_nettype none

`include "rp_config.svh"

module tb_rp_frontend;

  import rp_sample_pkg::*;
  import rp_regs_pkg::*;

  localparam int ACK_TMO = 16;                     // Cycles to wait for ack
  localparam int SMP_MAX = 2 ** (`SMP_DW - 1) - 1;
  localparam int SMP_MIN = -(2 ** (`SMP_DW - 1));

  logic               adc_clk = 1'b0;
  logic               rst_n_i;
  adc_raw_t           adc_a_dat_i, adc_b_dat_i;
  smp_t               gen_a_i, gen_b_i, ctl_a_i, ctl_b_i;
  smp_t               adc_a_o, adc_b_o;
  dac_code_t          dac_a_o, dac_b_o;
  sys_addr_t          sys_addr_i;
  sys_data_t          sys_wdata_i, sys_rdata_o;
  logic               sys_wen_i, sys_ren_i, sys_ack_o, sys_err_o;
  logic [7:0]         led_o;
  logic [`EXP_DW-1:0] exp_dat_i, exp_dat_o, exp_dir_o;
  logic [`PDM_N-1:0]  pdm_o;

  logic [31:0] lcg_state = 32'd66235;              // Fixed seed
  int          err_cnt = 0;
  int          test_cnt = 0;
  int          test_fail = 0;
  int          test_base;
  string       test_name;

  always #5 adc_clk = ~adc_clk;

  rp_frontend_top dut0 (.*);

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Saturated gen + ctl, as the loopback should deliver it
  function automatic smp_t sum_expect(input smp_t g, input smp_t c);
    int s;
    s = int'(g) + int'(c);
    if (s > SMP_MAX)
      s = SMP_MAX;
    else if (s < SMP_MIN)
      s = SMP_MIN;
    return smp_t'(s);
  endfunction

  function automatic int total_errors();
    return err_cnt + int'(dut0.u_chk.fail_cnt);   // Own checks plus assertions
  endfunction

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("FAIL %s %s expected %h actual %h", test_name, name, exp, act);
      err_cnt++;
    end
  endtask

  task automatic open_test(input string name);
    test_name = name;
    test_base = total_errors();
    test_cnt++;
  endtask

  task automatic close_test();
    int n;
    n = total_errors() - test_base;
    if (n == 0) begin
      $display("test %-10s ok", test_name);
    end else begin
      $display("test %-10s %0d errors", test_name, n);
      test_fail++;
    end
  endtask

  //////////////////////////////////////////////////
  // Bus access
  //////////////////////////////////////////////////

  task automatic bus_xfer(input logic wr, input sys_addr_t addr, input sys_data_t wdata,
                          output sys_data_t rdata, output logic err);
    int n;
    @(posedge adc_clk);
    sys_addr_i  <= addr;
    sys_wdata_i <= wdata;
    sys_wen_i   <= wr;
    sys_ren_i   <= !wr;
    @(posedge adc_clk);
    sys_wen_i <= 1'b0;                             // Single cycle strobe
    sys_ren_i <= 1'b0;
    n = 0;
    @(negedge adc_clk);
    while (!sys_ack_o && n < ACK_TMO) begin
      @(negedge adc_clk);
      n++;
    end
    if (!sys_ack_o) begin
      $display("bus access to address %h was never acknowledged", addr);
      err_cnt++;
    end
    rdata = sys_rdata_o;
    err   = sys_err_o;
  endtask

  task automatic write_reg(input sys_addr_t addr, input sys_data_t data);
    sys_data_t rd;
    logic      err;
    bus_xfer(1'b1, addr, data, rd, err);
  endtask

  task automatic read_check(input string name, input sys_addr_t addr, input sys_data_t exp);
    sys_data_t rd;
    logic      err;
    bus_xfer(1'b0, addr, '0, rd, err);
    check_value(name, exp, rd);
    check_value({name, "_err"}, 32'd0, 32'(err));
  endtask

  //////////////////////////////////////////////////
  // Sample stimulus
  //////////////////////////////////////////////////

  // Random words, every 4th cycle both channels overflow
  task automatic drive_samples(input int n);
    logic [31:0] r;
    logic [31:0] q;
    for (int i = 0; i < n; i++) begin
      @(posedge adc_clk);
      r = next_rand();
      q = next_rand();
      adc_a_dat_i <= r[15:0];
      adc_b_dat_i <= r[31:16];
      r = next_rand();
      if (i % 4 == 3) begin
        gen_a_i <= smp_t'(SMP_MAX);                // Positive overflow
        ctl_a_i <= smp_t'(SMP_MAX);
        gen_b_i <= smp_t'(SMP_MIN);                // Negative overflow
        ctl_b_i <= smp_t'(SMP_MIN);
      end else begin
        gen_a_i <= r[13:0];
        ctl_a_i <= r[27:14];
        gen_b_i <= q[13:0];
        ctl_b_i <= q[27:14];
      end
    end
  endtask

  task automatic check_loopback(input int n);
    logic [31:0] r;
    smp_t        ga;
    smp_t        ca;
    for (int i = 0; i < n; i++) begin
      @(posedge adc_clk);
      r  = next_rand();
      ga = r[13:0];
      ca = r[27:14];
      gen_a_i <= ga;
      ctl_a_i <= ca;
      gen_b_i <= ~ga;
      ctl_b_i <= ca;
      @(posedge adc_clk);                          // Sampled here
      @(negedge adc_clk);
      check_value("loopback_a", 32'(sum_expect(ga, ca)), 32'(adc_a_o));
      check_value("loopback_b", 32'(sum_expect(~ga, ca)), 32'(adc_b_o));
    end
  endtask

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////

  initial begin
    sys_data_t   rd;
    logic        err;
    int          cnt [`PDM_N];
    pdm_levels_t lv;
    rst_n_i     = 1'b0;
    adc_a_dat_i = '0;
    adc_b_dat_i = '0;
    gen_a_i     = '0;
    gen_b_i     = '0;
    ctl_a_i     = '0;
    ctl_b_i     = '0;
    sys_addr_i  = '0;
    sys_wdata_i = '0;
    sys_wen_i   = 1'b0;
    sys_ren_i   = 1'b0;
    exp_dat_i   = '0;
    repeat (5) @(posedge adc_clk);
    rst_n_i <= 1'b1;

    open_test("datapath");
    read_check("ctrl_rst", `REG_CTRL, 32'h0000_0000);   // Loopback off out of reset
    drive_samples(200);
    close_test();

    open_test("registers");
    read_check("id", `REG_ID, `BOARD_ID);
    write_reg(`REG_CTRL, 32'h0000_014A);           // LEDs A5, loopback off
    read_check("ctrl", `REG_CTRL, 32'h0000_014A);
    check_value("led_o", 32'h0000_00A5, 32'(led_o));
    write_reg(`REG_EXP_DIR, 32'h0000_003C);
    read_check("exp_dir", `REG_EXP_DIR, 32'h0000_003C);
    check_value("exp_dir_o", 32'h0000_003C, 32'(exp_dir_o));
    write_reg(`REG_EXP_OUT, 32'h0000_00C3);
    read_check("exp_out", `REG_EXP_OUT, 32'h0000_00C3);
    check_value("exp_dat_o", 32'h0000_00C3, 32'(exp_dat_o));
    write_reg(`REG_PDM, 32'h1164_FF00);
    read_check("pdm", `REG_PDM, 32'h1164_FF00);
    @(posedge adc_clk);
    exp_dat_i <= 8'h5A;
    repeat (2) @(posedge adc_clk);                 // Through the synchronizer
    read_check("exp_in", `REG_EXP_IN, 32'h0000_005A);
    write_reg(`REG_ID, 32'hFFFF_FFFF);             // Read only, dropped
    read_check("id_ro", `REG_ID, `BOARD_ID);
    close_test();

    open_test("bus");
    bus_xfer(1'b0, 16'h0040, '0, rd, err);
    check_value("unmapped_rd_err", 32'd1, 32'(err));
    check_value("unmapped_rdata", 32'd0, rd);
    bus_xfer(1'b1, 16'h0044, 32'hDEAD_BEEF, rd, err);
    check_value("unmapped_wr_err", 32'd1, 32'(err));
    close_test();

    open_test("loopback");
    write_reg(`REG_CTRL, 32'h0000_0001);
    check_loopback(50);
    write_reg(`REG_CTRL, 32'h0000_0000);
    read_check("ctrl_clr", `REG_CTRL, 32'h0000_0000);
    drive_samples(50);                             // ADC path back
    close_test();

    open_test("pdm");
    lv = 32'h1164_FF00;                            // Levels 0, 255, 100, 17
    write_reg(`REG_PDM, lv);
    repeat (`PDM_RNG) @(posedge adc_clk);
    for (int ch = 0; ch < `PDM_N; ch++)
      cnt[ch] = 0;
    repeat (`PDM_RNG) begin
      @(negedge adc_clk);
      for (int ch = 0; ch < `PDM_N; ch++)
        cnt[ch] += int'(pdm_o[ch]);
    end
    for (int ch = 0; ch < `PDM_N; ch++)
      check_value($sformatf("pdm_count%0d", ch), 32'(lv[ch]), 32'(cnt[ch]));
    close_test();

    $display("summary: %0d tests, %0d failed, %0d check errors, %0d assertion failures",
             test_cnt, test_fail, err_cnt, dut0.u_chk.fail_cnt);
    if (total_errors() == 0)
      $display("TESTS PASSED");
    else
      $display("TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+hdl
hdl/rp_sample_pkg.sv
hdl/rp_regs_pkg.sv
hdl/rp_adc_frontend.sv
hdl/rp_dac_backend.sv
hdl/rp_pdm.sv
hdl/rp_hk_regs.sv
hdl/rp_frontend_top.sv
tb/rp_frontend_assert.sv
tb/tb_rp_frontend.sv
